// File: include/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

//////////////////////////////
// Data memory geometry
//////////////////////////////

// Byte address width, word index is two bits narrower
`define MEM_ADDR_BITS 12

//////////////////////////////
// Display window
//////////////////////////////

// Words shown, counted from word 0
`define DISP_WORDS 8

// Clocks spent on each display word
`define SCAN_DIV 4

`endif

// File: source/wb_pkg.sv
`include "mem_config.svh"

package wb_pkg;

    // Word index into the data RAM
    typedef logic [`MEM_ADDR_BITS-3:0] word_idx_t;

    // Position inside the display window
    typedef logic [2:0] disp_idx_t;

    //////////////////////////////
    // Wishbone classic
    //////////////////////////////

    // Master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        word_idx_t   adr;
        logic [31:0] dat_w;
    } wb_m2s_t;

    // Slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_s2m_t;

    //////////////////////////////
    // Display port
    //////////////////////////////

    typedef struct packed {
        word_idx_t index;
    } disp_req_t;

    // One scanned word with its window position
    typedef struct packed {
        logic        valid;
        disp_idx_t   index;
        logic [31:0] word;
    } disp_frame_t;

endpackage

// File: source/lsu_pkg.sv
`include "mem_config.svh"

package lsu_pkg;

    // Access width of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_e;

    // Request from the core side, addr is a byte address
    typedef struct packed {
        logic                      write;
        acc_size_e                 size;
        logic                      sign_ext;
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic [31:0]               wdata;
    } lsu_req_t;

    // Response, rdata is zero for stores and errors
    typedef struct packed {
        logic        err;
        logic [31:0] rdata;
    } lsu_rsp_t;

    // Memory word seen whole or as byte lanes
    // Lane 0 holds bits 7:0
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } mem_word_u;

endpackage

// File: source/lsu_bus_master.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module lsu_bus_master
    import wb_pkg::*;
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  lsu_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output lsu_rsp_t rsp,
    input  logic     rsp_ready,
    output wb_m2s_t  wb_m,
    input  wb_s2m_t  wb_s
);

    typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_RESP} state_e;

    state_e      state;
    logic        accept;
    logic        misaligned;
    logic [3:0]  sel_d;
    mem_word_u   wdata_in;
    mem_word_u   st_word;
    mem_word_u   rd_word;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_data;

    // Request fields held for the bus cycle
    word_idx_t   adr_q;
    logic [3:0]  sel_q;
    logic        we_q;
    logic [31:0] dat_q;
    acc_size_e   size_q;
    logic        sign_q;
    logic [1:0]  lane_q;

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESP);
    assign accept    = req_valid && req_ready;

    //////////////////////////////
    // Request decode
    //////////////////////////////

    always_comb
    begin
        wdata_in.word = req.wdata;
        st_word.word  = req.wdata;
        misaligned    = 1'b0;
        sel_d         = 4'b0000;
        case (req.size)
            SIZE_BYTE:
            begin
                sel_d = 4'b0001 << req.addr[1:0];
                // Same byte on every lane
                for (int i = 0; i < 4; i++)
                begin
                    st_word.lane[i] = wdata_in.lane[0];
                end
            end
            SIZE_HALF:
            begin
                misaligned = req.addr[0];
                sel_d      = 4'b0011 << {req.addr[1], 1'b0};
                for (int i = 0; i < 4; i++)
                begin
                    st_word.lane[i] = wdata_in.lane[i % 2];
                end
            end
            SIZE_WORD:
            begin
                misaligned = (req.addr[1:0] != 2'b00);
                sel_d      = 4'b1111;
            end
            default:
                misaligned = 1'b1;
        endcase
    end

    // Load lane extraction from the returned word
    always_comb
    begin
        rd_word.word = wb_s.dat_r;
        ld_byte      = rd_word.lane[lane_q];
        ld_half      = {rd_word.lane[{lane_q[1], 1'b1}], rd_word.lane[{lane_q[1], 1'b0}]};
        case (size_q)
            SIZE_BYTE: ld_data = {{24{sign_q && ld_byte[7]}}, ld_byte};
            SIZE_HALF: ld_data = {{16{sign_q && ld_half[15]}}, ld_half};
            default:   ld_data = rd_word.word;
        endcase
    end

    //////////////////////////////
    // Controller
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE:
                    if (req_valid)
                        state <= misaligned ? ST_RESP : ST_BUS;
                ST_BUS:
                    if (wb_s.ack)
                        state <= ST_RESP;
                ST_RESP:
                    if (rsp_ready)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            adr_q     <= req.addr[`MEM_ADDR_BITS-1:2];
            sel_q     <= sel_d;
            we_q      <= req.write;
            dat_q     <= st_word.word;
            size_q    <= req.size;
            sign_q    <= req.sign_ext;
            lane_q    <= req.addr[1:0];
            rsp.err   <= misaligned;
            rsp.rdata <= 32'h0;
        end
        else if (state == ST_BUS && wb_s.ack)
            rsp.rdata <= we_q ? 32'h0 : ld_data;
    end

    // Strobe only while waiting for ack
    always_comb
    begin
        wb_m.cyc   = (state == ST_BUS);
        wb_m.stb   = (state == ST_BUS);
        wb_m.we    = we_q;
        wb_m.sel   = sel_q;
        wb_m.adr   = adr_q;
        wb_m.dat_w = dat_q;
    end

    // Ack only answers our own cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_s.ack |-> wb_m.cyc && wb_m.stb);

    a_sel_set: assert property (@(posedge clk) disable iff (rst)
        wb_m.stb |-> (wb_m.sel != 4'b0000));

    // Held until the slave answers
    a_bus_hold: assert property (@(posedge clk) disable iff (rst)
        wb_m.stb && !wb_s.ack |=> $stable(wb_m.adr) && $stable(wb_m.sel));

endmodule

// File: source/byte_lane_ram.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module byte_lane_ram
    import wb_pkg::*;
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  wb_m2s_t     wb_m,
    output wb_s2m_t     wb_s,
    input  disp_req_t   disp_req,
    output logic [31:0] disp_word
);

    localparam int DEPTH = 1 << (`MEM_ADDR_BITS - 2);

    mem_word_u mem [DEPTH];
    mem_word_u wr_word;
    logic      start;

    // New cycle seen and not yet acked
    assign start = wb_m.cyc && wb_m.stb && !wb_s.ack;

    always_comb
    begin
        wr_word.word = wb_m.dat_w;
    end

    //////////////////////////////
    // Bus write with lane merge
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (start && wb_m.we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wb_m.sel[i])
                    mem[wb_m.adr].lane[i] <= wr_word.lane[i];
            end
        end
    end

    //////////////////////////////
    // Bus read and ack
    //////////////////////////////

    // Whole word returned for the master to pick lanes
    always_ff @(posedge clk)
    begin
        if (rst)
            wb_s.ack <= 1'b0;
        else
        begin
            wb_s.ack <= start;
            if (start && !wb_m.we)
                wb_s.dat_r <= mem[wb_m.adr].word;
        end
    end

    // Display port reads one word per clock
    always_ff @(posedge clk)
    begin
        disp_word <= mem[disp_req.index].word;
    end

    // Master ends the cycle right after ack
    a_stb_drops: assert property (@(posedge clk) disable iff (rst)
        wb_s.ack |=> !wb_m.stb);

endmodule

// File: source/display_scan.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module display_scan
    import wb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output disp_req_t   disp_req,
    input  logic [31:0] disp_word,
    output disp_frame_t frame
);

    localparam int DIV_W = $clog2(`SCAN_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             step;
    disp_idx_t        idx;
    // Index of the word now on disp_word
    disp_idx_t        req_idx_q;
    logic             pend_q;

    assign step     = (div_cnt == DIV_W'(`SCAN_DIV - 1));
    assign disp_req = '{index: word_idx_t'(idx)};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt     <= '0;
            idx         <= '0;
            pend_q      <= 1'b0;
            frame.valid <= 1'b0;
            frame.index <= '0;
        end
        else
        begin
            div_cnt <= step ? '0 : div_cnt + 1'b1;
            if (step)
                idx <= (idx == disp_idx_t'(`DISP_WORDS - 1)) ? '0 : idx + 1'b1;
            pend_q    <= 1'b1;
            req_idx_q <= idx;
            // RAM answers one clock after the request
            if (pend_q)
            begin
                frame.valid <= 1'b1;
                frame.index <= req_idx_q;
                frame.word  <= disp_word;
            end
        end
    end

    // Frames walk the window in order and wrap at its end
    a_index_order: assert property (@(posedge clk) disable iff (rst)
        frame.valid && $changed(frame.index) |->
            frame.index == (($past(frame.index) == disp_idx_t'(`DISP_WORDS - 1)) ?
                            disp_idx_t'(0) : disp_idx_t'($past(frame.index) + 1'b1)));

endmodule

// File: source/data_mem_top.sv
`timescale 1ns/1ps

module data_mem_top
    import wb_pkg::*;
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  lsu_req_t    req,
    output logic        req_ready,
    output logic        rsp_valid,
    output lsu_rsp_t    rsp,
    input  logic        rsp_ready,
    output disp_frame_t frame
);

    // Wishbone link
    wb_m2s_t     wb_m;
    wb_s2m_t     wb_s;

    // Display link
    disp_req_t   disp_req;
    logic [31:0] disp_word;

    lsu_bus_master i_lsu_bus_master (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .wb_m      (wb_m),
        .wb_s      (wb_s)
    );

    byte_lane_ram i_byte_lane_ram (
        .clk       (clk),
        .rst       (rst),
        .wb_m      (wb_m),
        .wb_s      (wb_s),
        .disp_req  (disp_req),
        .disp_word (disp_word)
    );

    display_scan i_display_scan (
        .clk       (clk),
        .rst       (rst),
        .disp_req  (disp_req),
        .disp_word (disp_word),
        .frame     (frame)
    );

endmodule

// File: bench/tb_data_mem.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_data_mem
    import wb_pkg::*;
    import lsu_pkg::*;
();

    localparam int TIMEOUT   = 200;
    localparam int RAM_BYTES = 1 << `MEM_ADDR_BITS;

    logic        clk;
    logic        rst;
    logic        req_valid;
    lsu_req_t    req;
    logic        req_ready;
    logic        rsp_valid;
    lsu_rsp_t    rsp;
    logic        rsp_ready;
    disp_frame_t frame;

    // Byte-wide shadow of the data RAM
    logic [7:0]  shadow [RAM_BYTES];
    logic [31:0] rng;
    int          check_errors;
    int          timeouts;

    data_mem_top i_data_mem_top (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .frame     (frame)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return (a * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic lsu_req_t make_req(input logic write, input acc_size_e size,
                                          input logic sign, input int addr,
                                          input logic [31:0] data);
        lsu_req_t r;
        r.write    = write;
        r.size     = size;
        r.sign_ext = sign;
        r.addr     = addr[`MEM_ADDR_BITS-1:0];
        r.wdata    = data;
        return r;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic misaligned(input lsu_req_t r);
        return (r.size == SIZE_HALF && r.addr[0]) ||
               (r.size == SIZE_WORD && r.addr[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] shadow_word(input int widx);
        return {shadow[4*widx+3], shadow[4*widx+2], shadow[4*widx+1], shadow[4*widx]};
    endfunction

    function automatic lsu_rsp_t model_rsp(input lsu_req_t r);
        lsu_rsp_t    e;
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        a       = int'(r.addr);
        e.err   = misaligned(r);
        e.rdata = 32'h0;
        b       = shadow[a];
        h       = {shadow[a+1], shadow[a]};
        if (!e.err && !r.write)
        begin
            case (r.size)
                SIZE_BYTE: e.rdata = {{24{r.sign_ext & b[7]}}, b};
                SIZE_HALF: e.rdata = {{16{r.sign_ext & h[15]}}, h};
                default:   e.rdata = shadow_word(a / 4);
            endcase
        end
        return e;
    endfunction

    // Lowest byte of wdata goes to the lowest address
    task automatic model_store(input lsu_req_t r);
        int a;
        int n;
        a = int'(r.addr);
        n = (r.size == SIZE_BYTE) ? 1 : (r.size == SIZE_HALF) ? 2 : 4;
        if (r.write && !misaligned(r))
        begin
            for (int i = 0; i < n; i++)
                shadow[a+i] = r.wdata[8*i +: 8];
        end
    endtask

    //////////////////////////////
    // Checks and run control
    //////////////////////////////

    task automatic compare_rsp(input string tag, input lsu_rsp_t got, input lsu_rsp_t exp);
        if (got !== exp)
        begin
            check_errors++;
            $display("CHECK FAILED rsp (%s): got err=%h rdata=%h, expected err=%h rdata=%h",
                     tag, got.err, got.rdata, exp.err, exp.rdata);
        end
    endtask

    task automatic compare_frame(input disp_frame_t got, input disp_frame_t exp);
        if (got !== exp)
        begin
            check_errors++;
            $display("CHECK FAILED frame: got valid=%h index=%h word=%h", got.valid,
                     got.index, got.word);
            $display("    expected valid=%h index=%h word=%h", exp.valid, exp.index,
                     exp.word);
        end
    endtask

    task automatic compare_count(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timed out while waiting for %s", what);
    endtask

    //////////////////////////////
    // Bus-side tasks
    //////////////////////////////

    // All of these start and end on a falling edge
    task automatic wait_ready();
        int n;
        n = 0;
        while (!req_ready && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!req_ready)
            timed_out("req_ready");
    endtask

    task automatic send_req(input lsu_req_t r);
        wait_ready();
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_rsp(output int cycles);
        cycles = 1;
        while (!rsp_valid && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!rsp_valid)
            timed_out("rsp_valid");
    endtask

    task automatic run_access(input string tag, input lsu_req_t r);
        lsu_rsp_t exp;
        int       cycles;
        exp = model_rsp(r);
        send_req(r);
        wait_rsp(cycles);
        compare_rsp(tag, rsp, exp);
        compare_count("response latency", cycles, misaligned(r) ? 1 : 3);
        model_store(r);
        @(negedge clk);
    endtask

    task automatic store(input acc_size_e size, input int addr, input logic [31:0] data);
        run_access("store", make_req(1'b1, size, 1'b0, addr, data));
    endtask

    task automatic load(input acc_size_e size, input logic sign, input int addr);
        run_access("load", make_req(1'b0, size, sign, addr, 32'h0));
    endtask

    task automatic wait_frame_index(input int idx);
        int n;
        n = 0;
        while (!(frame.valid && int'(frame.index) == idx) && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!(frame.valid && int'(frame.index) == idx))
            timed_out("a display frame index");
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_word_access();
        for (int i = 0; i < `DISP_WORDS; i++)
        begin
            store(SIZE_WORD, 4 * i, fill_word(4 * i));
            load(SIZE_WORD, 1'b0, 4 * i);
        end
        // Top of memory
        store(SIZE_WORD, RAM_BYTES - 4, fill_word(RAM_BYTES - 4));
        load(SIZE_WORD, 1'b0, RAM_BYTES - 4);
    endtask

    task automatic test_byte_half();
        store(SIZE_WORD, 'h40, 32'h1122_3344);
        store(SIZE_BYTE, 'h41, 32'h0000_00a5);
        store(SIZE_HALF, 'h42, 32'hdead_8001);
        store(SIZE_BYTE, 'h40, 32'hffff_ff7f);
        load(SIZE_BYTE, 1'b1, 'h41);
        load(SIZE_BYTE, 1'b0, 'h41);
        load(SIZE_BYTE, 1'b1, 'h40);
        load(SIZE_HALF, 1'b1, 'h42);
        load(SIZE_HALF, 1'b0, 'h42);
        load(SIZE_HALF, 1'b1, 'h40);
        load(SIZE_WORD, 1'b0, 'h40);
    endtask

    task automatic test_misaligned();
        store(SIZE_WORD, 'h44, 32'h5566_7788);
        store(SIZE_HALF, 'h45, 32'h0000_beef);
        store(SIZE_WORD, 'h42, 32'hcafe_f00d);
        load(SIZE_HALF, 1'b1, 'h43);
        load(SIZE_WORD, 1'b0, 'h41);
        load(SIZE_WORD, 1'b0, 'h40);
        load(SIZE_WORD, 1'b0, 'h44);
    endtask

    task automatic test_back_pressure();
        lsu_req_t r;
        lsu_rsp_t exp;
        lsu_rsp_t held;
        int       cycles;
        store(SIZE_WORD, 'h80, 32'hc0de_5eed);
        r         = make_req(1'b0, SIZE_WORD, 1'b0, 'h80, 32'h0);
        exp       = model_rsp(r);
        rsp_ready = 1'b0;
        send_req(r);
        wait_rsp(cycles);
        held = rsp;
        compare_rsp("stalled load", held, exp);
        repeat (6)
        begin
            @(negedge clk);
            compare_rsp("held response", rsp, held);
            compare_count("rsp_valid", rsp_valid, 1);
            compare_count("req_ready", req_ready, 0);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        compare_count("rsp_valid", rsp_valid, 0);
        compare_count("req_ready", req_ready, 1);
    endtask

    task automatic test_display();
        int          seen [`DISP_WORDS];
        disp_frame_t exp;
        foreach (seen[i])
            seen[i] = 0;
        // Start on a fresh sweep
        wait_frame_index(`DISP_WORDS - 1);
        wait_frame_index(0);
        for (int k = 0; k < `DISP_WORDS * `SCAN_DIV; k++)
        begin
            exp.valid = 1'b1;
            exp.index = disp_idx_t'(k / `SCAN_DIV);
            exp.word  = shadow_word(k / `SCAN_DIV);
            compare_frame(frame, exp);
            seen[int'(frame.index)]++;
            @(negedge clk);
        end
        foreach (seen[i])
            compare_count("frames per index", seen[i], `SCAN_DIV);
    endtask

    task automatic test_random();
        lsu_req_t    r;
        logic [31:0] x;
        int          a;
        for (int w = 0; w < 16; w++)
            store(SIZE_WORD, 'h100 + 4 * w, fill_word('h100 + 4 * w));
        for (int k = 0; k < 200; k++)
        begin
            x          = next_rand();
            r.write    = x[0];
            r.size     = (x[2:1] == 2'd3) ? SIZE_WORD : acc_size_e'(x[2:1]);
            r.sign_ext = x[3];
            a          = 'h100 + int'(x[13:8]);
            // One in sixteen keeps its raw, possibly misaligned, address
            if (x[7:4] != 4'h0)
                a = (r.size == SIZE_WORD) ? (a & ~3) : (r.size == SIZE_HALF) ? (a & ~1) : a;
            r.addr  = a[`MEM_ADDR_BITS-1:0];
            r.wdata = next_rand();
            run_access("random", r);
        end
    endtask

    initial
    begin
        check_errors = 0;
        timeouts     = 0;
        rng          = 32'h03d8_c177;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b1;
        repeat (8)
            @(negedge clk);
        compare_count("req_ready", req_ready, 1);
        compare_count("rsp_valid", rsp_valid, 0);
        compare_count("frame.valid", frame.valid, 0);
        rst = 1'b0;
        @(negedge clk);
        test_word_access();
        test_byte_half();
        test_misaligned();
        test_back_pressure();
        test_display();
        test_random();
        finish_run();
    end

endmodule

// File: flist.f
+incdir+include
source/wb_pkg.sv
source/lsu_pkg.sv
source/lsu_bus_master.sv
source/byte_lane_ram.sv
source/display_scan.sv
source/data_mem_top.sv
bench/tb_data_mem.sv

// File: Makefile
TOP := tb_data_mem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
